// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_sb_core -f sb_core.f

out=$(./obj_dir/Vtb_sb_core +verilator+error+limit+1000 2>&1) || true
echo "$out"

if echo "$out" | grep -q "^RESULT: PASS$"; then
    exit 0
fi
exit 1

// File: sb_core.f
src/sb_pkg.sv
src/inst_window.sv
src/reg_status_table.sv
src/fu_station.sv
src/regfile.sv
src/sb_core_top.sv
tb/sb_core_assertions.sv
tb/tb_sb_core.sv

// File: src/fu_station.sv
`timescale 1ns/1ps

module fu_station
    import sb_pkg::*;
#(
    parameter int unsigned FU_ID   = 0,
    parameter int unsigned LATENCY = 1
) (
    input  logic      clk,
    input  logic      rst_ni,
    input  dispatch_t dispatch_i,
    input  src_tag_t  src1_tag_i,
    input  src_tag_t  src2_tag_i,
    input  retire_t   retire_i,
    output reg_idx_t  rs1_o,
    output reg_idx_t  rs2_o,
    input  xlen_t     rdata1_i,
    input  xlen_t     rdata2_i,
    output logic      busy_o,
    output complete_t complete_o
);

    localparam int unsigned CNT_W = $clog2(LATENCY + 1);
    typedef logic [CNT_W-1:0] cnt_t;

    logic        busy_q;
    logic        issued_q;
    cnt_t        cnt_q;     // 0 when idle
    src_tag_t    t1_q;
    src_tag_t    t2_q;
    alu_op_t     op_q;
    win_idx_t    idx_q;
    reg_idx_t    rs1_q;
    reg_idx_t    rs2_q;
    logic [15:0] imm_q;
    xlen_t       res_q;
    xlen_t       alu_res;
    logic        take;
    logic        ready;
    logic        own_retire;

    assign take       = dispatch_i.valid && dispatch_i.inst.fu_sel == 1'(FU_ID);
    assign ready      = busy_q & ~issued_q & ~t1_q.pending & ~t2_q.pending;
    assign own_retire = busy_q & retire_i.valid & (retire_i.idx == idx_q);

    always_comb begin
        case (op_q)
            OP_ADD:  alu_res = rdata1_i + rdata2_i;
            OP_SUB:  alu_res = rdata1_i - rdata2_i;
            OP_AND:  alu_res = rdata1_i & rdata2_i;
            OP_OR:   alu_res = rdata1_i | rdata2_i;
            OP_XOR:  alu_res = rdata1_i ^ rdata2_i;
            OP_LI:   alu_res = {{16{imm_q[15]}}, imm_q};
            default: alu_res = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q   <= 1'b0;
            issued_q <= 1'b0;
            cnt_q    <= '0;
            t1_q     <= '0;
            t2_q     <= '0;
        end else if (take) begin
            busy_q   <= 1'b1;
            issued_q <= 1'b0;
            t1_q     <= src1_tag_i;
            t2_q     <= src2_tag_i;
        end else begin
            if (retire_i.valid && t1_q.idx == retire_i.idx) t1_q.pending <= 1'b0;
            if (retire_i.valid && t2_q.idx == retire_i.idx) t2_q.pending <= 1'b0;
            if (ready) begin
                issued_q <= 1'b1;
                cnt_q    <= cnt_t'(LATENCY);
            end else if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end
            if (own_retire) begin  // unit free again
                busy_q   <= 1'b0;
                issued_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            op_q  <= dispatch_i.inst.op;
            idx_q <= dispatch_i.idx;
            rs1_q <= dispatch_i.inst.rs1;
            rs2_q <= dispatch_i.inst.rs2;
            imm_q <= dispatch_i.inst.imm;
        end
        if (ready) begin
            res_q <= alu_res;   // operands read at issue
        end
    end

    assign rs1_o      = rs1_q;
    assign rs2_o      = rs2_q;
    assign busy_o     = busy_q;
    assign complete_o = '{valid: cnt_q == cnt_t'(1), idx: idx_q, result: res_q};

endmodule

// File: src/inst_window.sv
`timescale 1ns/1ps

module inst_window
    import sb_pkg::*;
#(
    parameter int unsigned FULL_LEVEL = 14
) (
    input  logic      clk,
    input  logic      rst_ni,
    input  logic      in_valid_i,
    input  inst_t     in_inst_i,
    input  logic      fu_busy_i [NUM_FU],
    input  logic      dest_pending_i,
    input  complete_t complete_i [NUM_FU],
    output dispatch_t dispatch_o,
    output retire_t   retire_o,
    output xlen_t     head_pc_o,
    output logic      stall_o
);

    typedef logic [WIN_IDX_W:0] ptr_t;  // index plus wrap bit

    logic [WIN_DEPTH-1:0] valid_q;
    logic [WIN_DEPTH-1:0] disp_q;
    logic [WIN_DEPTH-1:0] done_q;
    inst_t                inst_q [WIN_DEPTH];
    xlen_t                res_q [WIN_DEPTH];   // completion buffer

    ptr_t     wptr_q;
    ptr_t     rptr_q;
    ptr_t     wptr_d;
    ptr_t     rptr_d;
    ptr_t     occ_d;
    win_idx_t dptr_q;
    win_idx_t widx;
    win_idx_t ridx;

    inst_t disp_inst;
    inst_t head_inst;
    logic  accept;
    logic  disp_ok;
    logic  retire_ok;

    assign accept    = in_valid_i & ~stall_o;
    assign widx      = wptr_q[WIN_IDX_W-1:0];
    assign ridx      = rptr_q[WIN_IDX_W-1:0];
    assign disp_inst = inst_q[dptr_q];
    assign head_inst = inst_q[ridx];

    // in order, one per cycle, no WAW on rd
    assign disp_ok = valid_q[dptr_q] & ~disp_q[dptr_q]
                   & ~fu_busy_i[disp_inst.fu_sel] & ~dest_pending_i;

    assign retire_ok = valid_q[ridx] & done_q[ridx];

    assign wptr_d = wptr_q + ptr_t'(accept);
    assign rptr_d = rptr_q + ptr_t'(retire_ok);
    assign occ_d  = wptr_d - rptr_d;

    always_ff @(posedge clk or negedge rst_ni) begin
        if (!rst_ni) begin
            wptr_q  <= '0;
            rptr_q  <= '0;
            dptr_q  <= '0;
            valid_q <= '0;
            disp_q  <= '0;
            done_q  <= '0;
            stall_o <= 1'b0;
        end else begin
            wptr_q  <= wptr_d;
            rptr_q  <= rptr_d;
            stall_o <= occ_d >= ptr_t'(FULL_LEVEL);
            if (accept) begin
                valid_q[widx] <= 1'b1;
                disp_q[widx]  <= 1'b0;
                done_q[widx]  <= 1'b0;
            end
            if (disp_ok) begin
                disp_q[dptr_q] <= 1'b1;
                dptr_q         <= dptr_q + 1'b1;
            end
            for (int f = 0; f < NUM_FU; f++) begin
                if (complete_i[f].valid) begin
                    done_q[complete_i[f].idx] <= 1'b1;
                end
            end
            if (retire_ok) begin  // free head entry
                valid_q[ridx] <= 1'b0;
                disp_q[ridx]  <= 1'b0;
                done_q[ridx]  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            inst_q[widx] <= in_inst_i;
        end
        for (int f = 0; f < NUM_FU; f++) begin
            if (complete_i[f].valid) begin
                res_q[complete_i[f].idx] <= complete_i[f].result;
            end
        end
    end

    assign dispatch_o = '{valid: disp_ok, idx: dptr_q, inst: disp_inst};

    assign retire_o = '{
        valid: retire_ok,
        idx:   ridx,
        rd:    head_inst.rd,
        wen:   retire_ok & (head_inst.rd != '0),   // r0 never written
        data:  res_q[ridx]
    };

    assign head_pc_o = head_inst.pc;

endmodule

// File: src/reg_status_table.sv
`timescale 1ns/1ps

module reg_status_table
    import sb_pkg::*;
(
    input  logic      clk,
    input  logic      rst_ni,
    input  dispatch_t dispatch_i,
    input  retire_t   retire_i,
    output src_tag_t  src1_tag_o,
    output src_tag_t  src2_tag_o,
    output logic      dest_pending_o
);

    src_tag_t owner_q [NUM_REGS];   // pending writer per register
    src_tag_t rd_tag;

    // producer retiring this cycle counts as already written
    function automatic src_tag_t bypass(src_tag_t t, retire_t r);
        src_tag_t o;
        o = t;
        if (r.valid && t.pending && t.idx == r.idx) begin
            o = '0;
        end
        return o;
    endfunction

    always_comb begin
        src1_tag_o = '0;
        src2_tag_o = '0;
        if (uses_src(dispatch_i.inst.op)) begin
            src1_tag_o = bypass(owner_q[dispatch_i.inst.rs1], retire_i);
            src2_tag_o = bypass(owner_q[dispatch_i.inst.rs2], retire_i);
        end
        rd_tag         = bypass(owner_q[dispatch_i.inst.rd], retire_i);
        dest_pending_o = rd_tag.pending;
    end

    always_ff @(posedge clk or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                owner_q[r] <= '0;
            end
        end else begin
            // only the current owner releases the register
            if (retire_i.valid && owner_q[retire_i.rd].pending &&
                owner_q[retire_i.rd].idx == retire_i.idx) begin
                owner_q[retire_i.rd] <= '0;
            end
            if (dispatch_i.valid && dispatch_i.inst.rd != '0) begin
                owner_q[dispatch_i.inst.rd] <= '{pending: 1'b1, idx: dispatch_i.idx};
            end
        end
    end

endmodule

// File: src/regfile.sv
`timescale 1ns/1ps

module regfile
    import sb_pkg::*;
(
    input  logic     clk,
    input  logic     rst_ni,
    input  reg_idx_t raddr_i [2*NUM_FU],
    output xlen_t    rdata_o [2*NUM_FU],
    input  retire_t  retire_i
);

    xlen_t mem_q [NUM_REGS];

    // architectural state starts at zero
    always_ff @(posedge clk or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                mem_q[r] <= '0;
            end
        end else if (retire_i.valid && retire_i.wen) begin
            mem_q[retire_i.rd] <= retire_i.data;
        end
    end

    always_comb begin
        for (int p = 0; p < 2 * NUM_FU; p++) begin
            rdata_o[p] = (raddr_i[p] == '0) ? '0 : mem_q[raddr_i[p]];   // r0 reads zero
        end
    end

endmodule

// File: src/sb_core_top.sv
`timescale 1ns/1ps

module sb_core_top
    import sb_pkg::*;
#(
    parameter int unsigned FULL_LEVEL = 14
) (
    input  logic      clk,
    input  logic      rst_ni,
    input  logic      in_valid_i,
    input  inst_t     in_inst_i,
    output logic      stall_o,
    output wb_trace_t wb_trace_o
);

    dispatch_t dispatch;
    retire_t   retire;
    complete_t complete [NUM_FU];
    logic      fu_busy [NUM_FU];
    src_tag_t  src1_tag;
    src_tag_t  src2_tag;
    logic      dest_pending;
    xlen_t     head_pc;
    reg_idx_t  rf_raddr [2*NUM_FU];
    xlen_t     rf_rdata [2*NUM_FU];

    inst_window #(
        .FULL_LEVEL (FULL_LEVEL)
    ) u_window (
        .clk            (clk),
        .rst_ni         (rst_ni),
        .in_valid_i     (in_valid_i),
        .in_inst_i      (in_inst_i),
        .fu_busy_i      (fu_busy),
        .dest_pending_i (dest_pending),
        .complete_i     (complete),
        .dispatch_o     (dispatch),
        .retire_o       (retire),
        .head_pc_o      (head_pc),
        .stall_o        (stall_o)
    );

    reg_status_table u_rst (
        .clk            (clk),
        .rst_ni         (rst_ni),
        .dispatch_i     (dispatch),
        .retire_i       (retire),
        .src1_tag_o     (src1_tag),
        .src2_tag_o     (src2_tag),
        .dest_pending_o (dest_pending)
    );

    // fast unit
    fu_station #(
        .FU_ID   (0),
        .LATENCY (1)
    ) u_fu0 (
        .clk        (clk),
        .rst_ni     (rst_ni),
        .dispatch_i (dispatch),
        .src1_tag_i (src1_tag),
        .src2_tag_i (src2_tag),
        .retire_i   (retire),
        .rs1_o      (rf_raddr[0]),
        .rs2_o      (rf_raddr[1]),
        .rdata1_i   (rf_rdata[0]),
        .rdata2_i   (rf_rdata[1]),
        .busy_o     (fu_busy[0]),
        .complete_o (complete[0])
    );

    // slow unit
    fu_station #(
        .FU_ID   (1),
        .LATENCY (3)
    ) u_fu1 (
        .clk        (clk),
        .rst_ni     (rst_ni),
        .dispatch_i (dispatch),
        .src1_tag_i (src1_tag),
        .src2_tag_i (src2_tag),
        .retire_i   (retire),
        .rs1_o      (rf_raddr[2]),
        .rs2_o      (rf_raddr[3]),
        .rdata1_i   (rf_rdata[2]),
        .rdata2_i   (rf_rdata[3]),
        .busy_o     (fu_busy[1]),
        .complete_o (complete[1])
    );

    regfile u_rf (
        .clk      (clk),
        .rst_ni   (rst_ni),
        .raddr_i  (rf_raddr),
        .rdata_o  (rf_rdata),
        .retire_i (retire)
    );

    assign wb_trace_o = '{
        valid: retire.valid,
        pc:    head_pc,
        wen:   retire.wen,
        wnum:  retire.rd,
        wdata: retire.data
    };

endmodule

// File: src/sb_pkg.sv
package sb_pkg;

    localparam int unsigned WIN_DEPTH = 16;
    localparam int unsigned WIN_IDX_W = $clog2(WIN_DEPTH);
    localparam int unsigned NUM_FU    = 2;
    localparam int unsigned NUM_REGS  = 32;

    typedef logic [31:0]          xlen_t;
    typedef logic [4:0]           reg_idx_t;
    typedef logic [WIN_IDX_W-1:0] win_idx_t;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_LI    // sign-extended imm
    } alu_op_t;

    // producer a source is waiting on
    typedef struct packed {
        logic     pending;
        win_idx_t idx;
    } src_tag_t;

    typedef struct packed {
        xlen_t       pc;
        alu_op_t     op;
        logic        fu_sel;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [15:0] imm;
    } inst_t;

    typedef struct packed {
        logic     valid;
        win_idx_t idx;
        inst_t    inst;
    } dispatch_t;

    typedef struct packed {
        logic     valid;
        win_idx_t idx;
        xlen_t    result;
    } complete_t;

    typedef struct packed {
        logic     valid;
        win_idx_t idx;
        reg_idx_t rd;
        logic     wen;
        xlen_t    data;
    } retire_t;

    typedef struct packed {
        logic     valid;
        xlen_t    pc;
        logic     wen;
        reg_idx_t wnum;
        xlen_t    wdata;
    } wb_trace_t;

    // LI is the only op without register sources
    function automatic logic uses_src(alu_op_t op);
        return op != OP_LI;
    endfunction

endpackage

// File: tb/sb_core_assertions.sv
`timescale 1ns/1ps

module sb_core_assertions
    import sb_pkg::*;
(
    input logic      clk,
    input logic      rst_ni,
    input logic      in_valid_i,
    input inst_t     in_inst_i,
    input logic      stall_o,
    input wb_trace_t wb_trace_o
);

    localparam int unsigned QD = 64;   // expectation ring

    xlen_t       arch_q [NUM_REGS];    // in-order register model
    xlen_t       exp_pc [QD];
    reg_idx_t    exp_wnum [QD];
    logic        exp_wen [QD];
    xlen_t       exp_wdata [QD];
    int unsigned push_cnt;
    int unsigned pop_cnt;
    int unsigned head;
    int unsigned fail_cnt = 0;
    logic        seen_accept;
    logic        accept;
    xlen_t       acc_res;
    xlen_t       head_pc;
    reg_idx_t    head_wnum;
    logic        head_wen;
    xlen_t       head_wdata;

    function automatic xlen_t model_alu(inst_t i, xlen_t a, xlen_t b);
        case (i.op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            default: return {{16{i.imm[15]}}, i.imm};   // li
        endcase
    endfunction

    assign accept     = in_valid_i & ~stall_o;
    assign acc_res    = model_alu(in_inst_i, arch_q[in_inst_i.rs1], arch_q[in_inst_i.rs2]);
    assign head       = pop_cnt % QD;
    assign head_pc    = exp_pc[head];
    assign head_wnum  = exp_wnum[head];
    assign head_wen   = exp_wen[head];
    assign head_wdata = exp_wdata[head];

    always_ff @(posedge clk or negedge rst_ni) begin
        if (!rst_ni) begin
            push_cnt    <= 0;
            pop_cnt     <= 0;
            seen_accept <= 1'b0;
            for (int r = 0; r < NUM_REGS; r++) begin
                arch_q[r] <= '0;
            end
        end else begin
            if (accept) begin
                push_cnt    <= push_cnt + 1;
                seen_accept <= 1'b1;
                if (in_inst_i.rd != '0) arch_q[in_inst_i.rd] <= acc_res;   // r0 stays zero
            end
            if (wb_trace_o.valid) pop_cnt <= pop_cnt + 1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            exp_pc[push_cnt % QD]    <= in_inst_i.pc;
            exp_wnum[push_cnt % QD]  <= in_inst_i.rd;
            exp_wen[push_cnt % QD]   <= in_inst_i.rd != '0;
            exp_wdata[push_cnt % QD] <= acc_res;
        end
    end

    a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_ni)
        !seen_accept |-> !stall_o && !wb_trace_o.valid)
        else begin
            fail_cnt++;
            $error("stall_o or wb_trace_o.valid went high before any instruction was accepted");
        end

    a_retire_has_owner: assert property (@(posedge clk) disable iff (!rst_ni)
        wb_trace_o.valid |-> push_cnt != pop_cnt)
        else begin
            fail_cnt++;
            $error("an instruction retired that was never accepted");
        end

    a_window_bound: assert property (@(posedge clk) disable iff (!rst_ni)
        push_cnt - pop_cnt <= WIN_DEPTH)
        else begin
            fail_cnt++;
            $error("more instructions outstanding than the window has entries");
        end

    a_pc: assert property (@(posedge clk) disable iff (!rst_ni)
        wb_trace_o.valid |-> wb_trace_o.pc == head_pc)
        else begin
            fail_cnt++;
            $error("mismatch wb_trace_o.pc exp %h got %h",
                   $sampled(head_pc), $sampled(wb_trace_o.pc));
        end

    a_wnum: assert property (@(posedge clk) disable iff (!rst_ni)
        wb_trace_o.valid |-> wb_trace_o.wnum == head_wnum)
        else begin
            fail_cnt++;
            $error("mismatch wb_trace_o.wnum exp %h got %h",
                   $sampled(head_wnum), $sampled(wb_trace_o.wnum));
        end

    a_wen: assert property (@(posedge clk) disable iff (!rst_ni)
        wb_trace_o.valid |-> wb_trace_o.wen == head_wen)
        else begin
            fail_cnt++;
            $error("mismatch wb_trace_o.wen exp %h got %h",
                   $sampled(head_wen), $sampled(wb_trace_o.wen));
        end

    a_wdata: assert property (@(posedge clk) disable iff (!rst_ni)
        wb_trace_o.valid |-> wb_trace_o.wdata == head_wdata)
        else begin
            fail_cnt++;
            $error("mismatch wb_trace_o.wdata exp %h got %h",
                   $sampled(head_wdata), $sampled(wb_trace_o.wdata));
        end

endmodule

bind sb_core_top sb_core_assertions u_chk (
    .clk        (clk),
    .rst_ni     (rst_ni),
    .in_valid_i (in_valid_i),
    .in_inst_i  (in_inst_i),
    .stall_o    (stall_o),
    .wb_trace_o (wb_trace_o)
);

// File: tb/tb_sb_core.sv
`timescale 1ns/1ps

module tb_sb_core;
    import sb_pkg::*;

    localparam int unsigned TIMEOUT = 300;   // cycles per wait

    logic      clk;
    logic      rst_ni;
    logic      in_valid_i;
    inst_t     in_inst_i;
    logic      stall_o;
    wb_trace_t wb_trace_o;

    int          seed = 32'ha575_d682;
    xlen_t       pc;
    int unsigned accepted;
    int unsigned retired;
    int unsigned timeouts;
    int unsigned lost;
    int unsigned stall_cycles;
    int unsigned other_fails;

    sb_core_top dut_i (
        .clk        (clk),
        .rst_ni     (rst_ni),
        .in_valid_i (in_valid_i),
        .in_inst_i  (in_inst_i),
        .stall_o    (stall_o),
        .wb_trace_o (wb_trace_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // outputs are stable mid-cycle
    always @(negedge clk) begin
        if (rst_ni && wb_trace_o.valid) retired++;
        if (rst_ni && stall_o) stall_cycles++;
    end

    function automatic inst_t build_inst(alu_op_t op, logic fu, reg_idx_t rd,
                                         reg_idx_t rs1, reg_idx_t rs2, logic [15:0] imm);
        inst_t i;
        i = '0;
        i.op     = op;
        i.fu_sel = fu;
        i.rd     = rd;
        i.rs1    = rs1;
        i.rs2    = rs2;
        i.imm    = imm;
        return i;
    endfunction

    function automatic reg_idx_t pick_reg();
        int unsigned r;
        r = $unsigned($random(seed)) % 8;
        return (r < 6) ? reg_idx_t'(1 + r % 4) : reg_idx_t'(r + 2);   // mostly r1..r4
    endfunction

    function automatic inst_t random_inst();
        alu_op_t op;
        op = alu_op_t'($unsigned($random(seed)) % 6);
        return build_inst(op, 1'($random(seed)), pick_reg(), pick_reg(), pick_reg(),
                          16'($random(seed)));
    endfunction

    // called on a rising edge, returns on the edge that accepts
    task automatic send_inst(input inst_t inst);
        inst_t       i;
        int unsigned waited;
        i      = inst;
        i.pc   = pc;
        pc     = pc + 4;
        waited = 0;
        in_valid_i <= 1'b1;
        in_inst_i  <= i;
        @(negedge clk);
        while (stall_o && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (stall_o) begin
            timeouts++;
            $display("timeout: stall_o stayed high for %0d cycles", TIMEOUT);
        end else begin
            accepted++;
        end
        @(posedge clk);
    endtask

    task automatic idle_cycles(input int unsigned n);
        in_valid_i <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    initial begin
        int unsigned waited;
        rst_ni       = 1'b0;
        in_valid_i   = 1'b0;
        in_inst_i    = '0;
        pc           = 32'h0000_1000;
        accepted     = 0;
        retired      = 0;
        timeouts     = 0;
        lost         = 0;
        stall_cycles = 0;
        other_fails  = 0;
        repeat (5) @(posedge clk);
        rst_ni <= 1'b1;
        idle_cycles(4);

        for (int r = 1; r <= 8; r++) begin   // li only
            send_inst(build_inst(OP_LI, 1'($random(seed)), reg_idx_t'(r), '0, '0,
                                 16'($random(seed))));
        end

        for (int n = 0; n < 60; n++) begin   // dependent mix over both units
            send_inst(random_inst());
            if ($unsigned($random(seed)) % 4 == 0) idle_cycles(1 + $unsigned($random(seed)) % 3);
        end

        // r3 written four times, then read
        send_inst(build_inst(OP_LI, 1'b0, 5'd3, '0, '0, 16'h0011));
        send_inst(build_inst(OP_ADD, 1'b1, 5'd3, 5'd3, 5'd3, '0));
        send_inst(build_inst(OP_XOR, 1'b0, 5'd3, 5'd3, 5'd1, '0));
        send_inst(build_inst(OP_SUB, 1'b1, 5'd3, 5'd3, 5'd2, '0));
        send_inst(build_inst(OP_OR, 1'b0, 5'd5, 5'd3, 5'd3, '0));
        send_inst(build_inst(OP_ADD, 1'b1, 5'd6, 5'd3, 5'd5, '0));

        stall_cycles = 0;
        for (int n = 0; n < 24; n++) begin   // chain on r1 through the slow unit
            send_inst(build_inst(OP_ADD, 1'b1, 5'd1, 5'd1, 5'd2, '0));
        end
        if (stall_cycles == 0) begin
            other_fails++;
            $display("stall_o never went high during the slow unit burst");
        end

        send_inst(build_inst(OP_ADD, 1'b0, 5'd0, 5'd1, 5'd2, '0));
        send_inst(build_inst(OP_LI, 1'b1, 5'd0, '0, '0, 16'h8001));
        send_inst(build_inst(OP_ADD, 1'b0, 5'd7, 5'd0, 5'd1, '0));
        send_inst(build_inst(OP_OR, 1'b1, 5'd8, 5'd0, 5'd0, '0));
        idle_cycles(1);

        waited = 0;
        while (retired != accepted && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (retired < accepted) begin
            lost = accepted - retired;
            $display("%0d accepted instructions never retired", lost);
        end
        idle_cycles(3);

        $display("accepted %0d retired %0d timeouts %0d lost %0d other %0d assertion failures %0d",
                 accepted, retired, timeouts, lost, other_fails, dut_i.u_chk.fail_cnt);
        if (timeouts + lost + other_fails + dut_i.u_chk.fail_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
